// File: hw/cmPkg.sv
`default_nettype none

package cmPkg;

  // Code memory geometry
  localparam int CM_ADDR_W = 14;             // Full code memory address
  localparam int CM_DATA_W = 24;             // One instruction word
  localparam int OVL_W     = 4;              // Overlay index from core or boot side
  localparam int NUM_OVL   = 8;              // Indexes 8..15 select no bank

  localparam int BASE_AW    = 13;            // Base bank covers 8K words
  localparam int OVL_AW     = 12;            // Each overlay bank covers 4K words
  localparam int BASE_DEPTH = 1 << BASE_AW;
  localparam int OVL_DEPTH  = 1 << OVL_AW;

  // Boot loader byte stream
  localparam int BYTE_W         = 8;
  localparam int BYTES_PER_WORD = 3;         // Three bytes per 24-bit word
  localparam int BYTE_IDX_W     = 2;         // Enough for index 0..2
  localparam int BOOT_LEN_W     = 8;         // Word count where 0 means 256

  // Boot loader FSM
  typedef enum logic [1:0] {
    BOOT_IDLE,                               // Waiting for bootStart
    BOOT_LOAD,                               // Collecting bytes of the current word
    BOOT_WRITE,                              // Single write cycle into code memory
    BOOT_DONE                                // One-cycle completion pulse
  } bootState_e;

endpackage

`default_nettype wire

// File: hw/bootSeq.sv
`timescale 1ns/100ps
`default_nettype none

module bootSeq (
  input  logic DSPCLK,
  input  logic rst,
  input  logic bootStart,                    // Single-cycle start strobe
  input  logic byteValid,                    // One byte per strobe cycle
  input  logic lastByte,                     // Current byte completes the word
  input  logic lastWord,                     // Word being written is the final one
  output logic bootBusy,
  output logic cntClear,
  output logic byteAdvance,
  output logic wordAdvance,
  output logic cmWrite,
  output logic bootDone
);

  import cmPkg::*;

  bootState_e state;
  bootState_e nextState;

  always_ff @(posedge DSPCLK)
  begin
    if (rst)
      state <= BOOT_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      BOOT_IDLE:
        if (bootStart)
          nextState = BOOT_LOAD;
      BOOT_LOAD:
        if (byteValid && lastByte)
          nextState = BOOT_WRITE;            // Third byte is in the assembler
      BOOT_WRITE:
        nextState = lastWord ? BOOT_DONE : BOOT_LOAD;
      BOOT_DONE:
        nextState = BOOT_IDLE;
      default:
        nextState = BOOT_IDLE;
    endcase
  end

  assign bootBusy    = (state != BOOT_IDLE);
  assign cntClear    = (state == BOOT_IDLE) && bootStart;
  assign byteAdvance = (state == BOOT_LOAD) && byteValid; // Bytes outside LOAD are dropped
  assign cmWrite     = (state == BOOT_WRITE);
  assign wordAdvance = (state == BOOT_WRITE);             // Step address after this write
  assign bootDone    = (state == BOOT_DONE);

  // A write always follows directly on the third byte of a word
  assert property (@(posedge DSPCLK) disable iff (rst)
    cmWrite |-> $past(byteAdvance && lastByte))
    else $error("bootSeq: cmWrite without a completed word");

endmodule

`default_nettype wire

// File: hw/byteCounter.sv
`timescale 1ns/100ps
`default_nettype none

module byteCounter (
  input  logic                         DSPCLK,
  input  logic                         rst,
  input  logic                         cntClear,     // Start of a boot block
  input  logic                         byteAdvance,
  input  logic                         wordAdvance,
  input  logic [cmPkg::CM_ADDR_W-1:0]  bootAddr,     // Held while the boot runs
  input  logic [cmPkg::BOOT_LEN_W-1:0] bootLen,
  output logic                         lastByte,
  output logic                         lastWord,
  output logic [cmPkg::CM_ADDR_W-1:0]  bootWrAddr
);

  import cmPkg::*;

  logic [BYTE_IDX_W-1:0] byteIdx;
  logic [BOOT_LEN_W-1:0] wordCnt;
  logic [BOOT_LEN_W-1:0] lenMinusOne;

  always_ff @(posedge DSPCLK)
  begin
    if (rst || cntClear)
    begin
      byteIdx <= '0;
      wordCnt <= '0;
    end
    else
    begin
      if (byteAdvance)
        byteIdx <= lastByte ? '0 : byteIdx + 1'b1; // Wrap after the third byte
      if (wordAdvance)
        wordCnt <= wordCnt + 1'b1;
    end
  end

  assign lenMinusOne = bootLen - 1'b1;                  // Length 0 wraps to 255 for 256 words
  assign lastByte    = (byteIdx == BYTE_IDX_W'(BYTES_PER_WORD - 1));
  assign lastWord    = (wordCnt == lenMinusOne);
  assign bootWrAddr  = bootAddr + CM_ADDR_W'(wordCnt);

  assert property (@(posedge DSPCLK) disable iff (rst)
    byteIdx != 2'd3)
    else $error("byteCounter: byte index out of range");

endmodule

`default_nettype wire

// File: hw/wordAssembler.sv
`timescale 1ns/100ps
`default_nettype none

module wordAssembler (
  input  logic                        DSPCLK,
  input  logic                        rst,
  input  logic                        byteAdvance, // Accepted boot byte
  input  logic [cmPkg::BYTE_W-1:0]    byteData,
  output logic [cmPkg::CM_DATA_W-1:0] bootWord
);

  import cmPkg::*;

  // Each new byte enters at the low end, so after three bytes
  // the first one received sits in bits 23:16
  always_ff @(posedge DSPCLK)
  begin
    if (rst)
      bootWord <= '0;
    else if (byteAdvance)
      bootWord <= {bootWord[CM_DATA_W-BYTE_W-1:0], byteData};
  end

endmodule

`default_nettype wire

// File: hw/cmSelect.sv
`timescale 1ns/100ps
`default_nettype none

module cmSelect (
  input  logic                        DSPCLK,
  input  logic                        rst,
  input  logic                        pmBdrySel,  // 1 selects the 4K boundary
  input  logic                        extMemSel,  // External memory gives no internal select
  input  logic                        coreFetch,
  input  logic [cmPkg::CM_ADDR_W-1:0] coreAddr,
  input  logic [cmPkg::OVL_W-1:0]     coreOvl,
  input  logic                        bootBusy,
  input  logic                        cmWrite,
  input  logic [cmPkg::CM_ADDR_W-1:0] bootWrAddr,
  input  logic [cmPkg::OVL_W-1:0]     bootOvl,
  input  logic [cmPkg::CM_DATA_W-1:0] bootWord,
  output logic                        cmCs,
  output logic [cmPkg::NUM_OVL-1:0]   ovlCs,
  output logic                        cmOe,
  output logic [cmPkg::NUM_OVL-1:0]   ovlOe,
  output logic                        cmWe,
  output logic [cmPkg::CM_ADDR_W-1:0] memAddr,
  output logic [cmPkg::CM_DATA_W-1:0] memWdata
);

  import cmPkg::*;

  typedef enum logic [1:0] {
    RGN_NONE,
    RGN_BASE,
    RGN_OVL
  } region_e;

  logic [OVL_W-1:0]     ovl;
  logic [CM_ADDR_W-1:0] addr;
  logic                 strobe;
  logic                 csEn;
  logic [1:0]           topBits;
  region_e              region;

  // Boot side owns the memory for the whole boot sequence
  assign ovl    = bootBusy ? bootOvl : coreOvl;
  assign addr   = bootBusy ? bootWrAddr : coreAddr;
  assign strobe = bootBusy ? cmWrite : coreFetch;
  assign csEn   = strobe && !extMemSel;

  assign topBits = addr[CM_ADDR_W-1:CM_ADDR_W-2];

  always_comb
  begin
    region = RGN_NONE;
    if (pmBdrySel)
    begin
      if (topBits == 2'b00)
        region = RGN_BASE;                    // 4K base
      else if (topBits == 2'b01)
        region = RGN_OVL;
    end
    else
    begin
      if (!topBits[1])
        region = RGN_BASE;                    // 8K base
      else if (topBits == 2'b10)
        region = RGN_OVL;
    end
  end

  assign cmCs = csEn && (region == RGN_BASE);

  // Indexes past the last bank match no select line
  always_comb
  begin
    for (int i = 0; i < NUM_OVL; i++)
      ovlCs[i] = csEn && (region == RGN_OVL) && (ovl == OVL_W'(i));
  end

  // Enables follow a fetch select by one cycle
  always_ff @(posedge DSPCLK)
  begin
    if (rst)
    begin
      cmOe  <= 1'b0;
      ovlOe <= '0;
    end
    else
    begin
      cmOe  <= cmCs && !bootBusy;
      ovlOe <= bootBusy ? '0 : ovlCs;
    end
  end

  assign cmWe     = bootBusy && cmWrite;
  assign memAddr  = addr;
  assign memWdata = bootWord;

  assert property (@(posedge DSPCLK) disable iff (rst)
    $onehot0({cmCs, ovlCs}))
    else $error("cmSelect: more than one bank selected");

endmodule

`default_nettype wire

// File: hw/codeMem.sv
`timescale 1ns/100ps
`default_nettype none

module codeMem (
  input  logic                        DSPCLK,
  input  logic                        cmCs,
  input  logic [cmPkg::NUM_OVL-1:0]   ovlCs,
  input  logic                        cmOe,      // Registered to line up with read data
  input  logic [cmPkg::NUM_OVL-1:0]   ovlOe,
  input  logic                        cmWe,
  input  logic [cmPkg::CM_ADDR_W-1:0] memAddr,
  input  logic [cmPkg::CM_DATA_W-1:0] memWdata,
  output logic [cmPkg::CM_DATA_W-1:0] readData,
  output logic                        readValid
);

  import cmPkg::*;

  logic [CM_DATA_W-1:0] baseMem [BASE_DEPTH];
  logic [CM_DATA_W-1:0] baseRd;
  logic [CM_DATA_W-1:0] ovlRd [NUM_OVL];

  always_ff @(posedge DSPCLK)
  begin
    if (cmCs)
    begin
      if (cmWe)
        baseMem[memAddr[BASE_AW-1:0]] <= memWdata;
      else
        baseRd <= baseMem[memAddr[BASE_AW-1:0]];
    end
  end

  for (genvar g = 0; g < NUM_OVL; g++)
  begin : gOvlBank
    logic [CM_DATA_W-1:0] ovlMem [OVL_DEPTH];

    always_ff @(posedge DSPCLK)
    begin
      if (ovlCs[g])
      begin
        if (cmWe)
          ovlMem[memAddr[OVL_AW-1:0]] <= memWdata;
        else
          ovlRd[g] <= ovlMem[memAddr[OVL_AW-1:0]];
      end
    end
  end

  always_comb
  begin
    readData = '0;
    if (cmOe)
      readData = baseRd;
    for (int i = 0; i < NUM_OVL; i++)
      if (ovlOe[i])
        readData = ovlRd[i];                   // At most one enable is high
  end

  assign readValid = cmOe || (|ovlOe);

endmodule

`default_nettype wire

// File: hw/cmSubsys.sv
`timescale 1ns/100ps
`default_nettype none

module cmSubsys (
  input  logic                         DSPCLK,
  input  logic                         rst,
  input  logic                         pmBdrySel,
  input  logic                         extMemSel,
  input  logic                         coreFetch,
  input  logic [cmPkg::CM_ADDR_W-1:0]  coreAddr,
  input  logic [cmPkg::OVL_W-1:0]      coreOvl,
  output logic [cmPkg::CM_DATA_W-1:0]  readData,
  output logic                         readValid,
  input  logic                         bootStart,
  input  logic [cmPkg::CM_ADDR_W-1:0]  bootAddr,
  input  logic [cmPkg::OVL_W-1:0]      bootOvl,
  input  logic [cmPkg::BOOT_LEN_W-1:0] bootLen,
  input  logic                         byteValid,
  input  logic [cmPkg::BYTE_W-1:0]     byteData,
  output logic                         bootBusy,
  output logic                         bootDone
);

  import cmPkg::*;

  logic                 cntClear;
  logic                 byteAdvance;
  logic                 wordAdvance;
  logic                 cmWrite;
  logic                 lastByte;
  logic                 lastWord;
  logic [CM_ADDR_W-1:0] bootWrAddr;
  logic [CM_DATA_W-1:0] bootWord;
  logic                 cmCs;
  logic [NUM_OVL-1:0]   ovlCs;
  logic                 cmOe;
  logic [NUM_OVL-1:0]   ovlOe;
  logic                 cmWe;
  logic [CM_ADDR_W-1:0] memAddr;
  logic [CM_DATA_W-1:0] memWdata;

  bootSeq uBootSeq (
    .DSPCLK      (DSPCLK),
    .rst         (rst),
    .bootStart   (bootStart),
    .byteValid   (byteValid),
    .lastByte    (lastByte),
    .lastWord    (lastWord),
    .bootBusy    (bootBusy),
    .cntClear    (cntClear),
    .byteAdvance (byteAdvance),
    .wordAdvance (wordAdvance),
    .cmWrite     (cmWrite),
    .bootDone    (bootDone)
  );

  byteCounter uByteCounter (
    .DSPCLK      (DSPCLK),
    .rst         (rst),
    .cntClear    (cntClear),
    .byteAdvance (byteAdvance),
    .wordAdvance (wordAdvance),
    .bootAddr    (bootAddr),
    .bootLen     (bootLen),
    .lastByte    (lastByte),
    .lastWord    (lastWord),
    .bootWrAddr  (bootWrAddr)
  );

  wordAssembler uWordAssembler (
    .DSPCLK      (DSPCLK),
    .rst         (rst),
    .byteAdvance (byteAdvance),
    .byteData    (byteData),
    .bootWord    (bootWord)
  );

  cmSelect uCmSelect (
    .DSPCLK     (DSPCLK),
    .rst        (rst),
    .pmBdrySel  (pmBdrySel),
    .extMemSel  (extMemSel),
    .coreFetch  (coreFetch),
    .coreAddr   (coreAddr),
    .coreOvl    (coreOvl),
    .bootBusy   (bootBusy),
    .cmWrite    (cmWrite),
    .bootWrAddr (bootWrAddr),
    .bootOvl    (bootOvl),
    .bootWord   (bootWord),
    .cmCs       (cmCs),
    .ovlCs      (ovlCs),
    .cmOe       (cmOe),
    .ovlOe      (ovlOe),
    .cmWe       (cmWe),
    .memAddr    (memAddr),
    .memWdata   (memWdata)
  );

  codeMem uCodeMem (
    .DSPCLK    (DSPCLK),
    .cmCs      (cmCs),
    .ovlCs     (ovlCs),
    .cmOe      (cmOe),
    .ovlOe     (ovlOe),
    .cmWe      (cmWe),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .readData  (readData),
    .readValid (readValid)
  );

endmodule

`default_nettype wire

// File: sim/cmSubsysTb.sv
`timescale 1ns/100ps
`default_nettype none

module cmSubsysTb;

  import cmPkg::*;

  localparam int NO_BANK    = -1;
  localparam int BASE_BANK  = NUM_OVL;          // Bank code for the base bank
  localparam int PASS_BOOT  = (4 * 256 + 2) + (4 * 4 + 2) + 4 * (4 * 16 + 2);
  localparam int PASS_FETCH = (256 + 1) + 4 * (16 + 1) + 12;
  localparam int MAX_CYCLES = 4 * (2 * (PASS_BOOT + PASS_FETCH));

  logic                  DSPCLK = 1'b0;
  logic                  rst;
  logic                  pmBdrySel;
  logic                  extMemSel;
  logic                  coreFetch;
  logic [CM_ADDR_W-1:0]  coreAddr;
  logic [OVL_W-1:0]      coreOvl;
  logic [CM_DATA_W-1:0]  readData;
  logic                  readValid;
  logic                  bootStart;
  logic [CM_ADDR_W-1:0]  bootAddr;
  logic [OVL_W-1:0]      bootOvl;
  logic [BOOT_LEN_W-1:0] bootLen;
  logic                  byteValid;
  logic [BYTE_W-1:0]     byteData;
  logic                  bootBusy;
  logic                  bootDone;

  logic                  expValid;
  logic [CM_DATA_W-1:0]  expData;
  logic                  prevExpValid = 1'b0;   // Expectation for the cycle after the fetch
  logic [CM_DATA_W-1:0]  prevExpData = '0;
  logic                  expBusy;
  logic                  expDone;
  int                    errCount = 0;
  int                    cycleCount = 0;
  int                    fetchCount = 0;
  int                    bootCount = 0;

  logic [CM_DATA_W-1:0]  refBase [BASE_DEPTH];   // Reference model with one array per bank
  logic [CM_DATA_W-1:0]  refOvl [NUM_OVL][OVL_DEPTH];

  cmSubsys uut (
    .DSPCLK    (DSPCLK),
    .rst       (rst),
    .pmBdrySel (pmBdrySel),
    .extMemSel (extMemSel),
    .coreFetch (coreFetch),
    .coreAddr  (coreAddr),
    .coreOvl   (coreOvl),
    .readData  (readData),
    .readValid (readValid),
    .bootStart (bootStart),
    .bootAddr  (bootAddr),
    .bootOvl   (bootOvl),
    .bootLen   (bootLen),
    .byteValid (byteValid),
    .byteData  (byteData),
    .bootBusy  (bootBusy),
    .bootDone  (bootDone)
  );

  always #5 DSPCLK = ~DSPCLK;

  always @(posedge DSPCLK)
  begin
    prevExpValid <= expValid;
    prevExpData  <= expData;
    cycleCount   <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // Bank code from the 4K or 8K region rules
  function automatic int decodeBank(input logic [CM_ADDR_W-1:0] addr,
                                    input logic [OVL_W-1:0] ovl, input logic bdry);
    logic isBase;
    logic isOvl;
    if (bdry)
    begin
      isBase = (addr[13:12] == 2'b00);
      isOvl  = (addr[13:12] == 2'b01);
    end
    else
    begin
      isBase = !addr[13];
      isOvl  = (addr[13:12] == 2'b10);
    end
    if (isBase)
      return BASE_BANK;
    if (isOvl && (int'(ovl) < NUM_OVL))
      return int'(ovl);
    return NO_BANK;
  endfunction

  task automatic nextCycle();
    @(posedge DSPCLK);
    #1;
  endtask

  task automatic idleCycle();
    coreFetch = 1'b0;
    expValid  = 1'b0;
    nextCycle();
  endtask

  task automatic bootBlock(input logic [CM_ADDR_W-1:0] addr, input logic [OVL_W-1:0] ovl,
                           input logic [BOOT_LEN_W-1:0] lenCode);
    int                   n;
    int                   bank;
    logic [31:0]          r;
    logic [CM_DATA_W-1:0] w;
    logic [CM_ADDR_W-1:0] a;
    n         = (lenCode == '0) ? 256 : int'(lenCode);
    bootAddr  = addr;
    bootOvl   = ovl;
    bootLen   = lenCode;
    bootStart = 1'b1;
    nextCycle();
    bootStart = 1'b0;
    expBusy   = 1'b1;                          // Busy from the edge after the start pulse
    for (int k = 0; k < n; k++)
    begin
      r = $urandom();
      w = r[CM_DATA_W-1:0];
      for (int j = 0; j < BYTES_PER_WORD; j++)
      begin
        byteData  = w[CM_DATA_W-1-8*j -: 8];   // Most significant byte first
        byteValid = 1'b1;
        coreFetch = (k == 0) && (j == 1);      // Core fetch during boot is ignored
        coreAddr  = addr;
        coreOvl   = ovl;
        nextCycle();
      end
      byteValid = 1'b0;
      coreFetch = 1'b0;
      a    = addr + CM_ADDR_W'(k);
      bank = decodeBank(a, ovl, pmBdrySel);
      if (bank == BASE_BANK)
        refBase[a[BASE_AW-1:0]] = w;
      else if (bank != NO_BANK)
        refOvl[bank][a[OVL_AW-1:0]] = w;
      nextCycle();                             // Write cycle
    end
    expDone = 1'b1;
    nextCycle();
    expDone = 1'b0;
    expBusy = 1'b0;
    bootCount++;
  endtask

  task automatic fetchWord(input logic [CM_ADDR_W-1:0] addr, input logic [OVL_W-1:0] ovl);
    int bank;
    bank      = decodeBank(addr, ovl, pmBdrySel);
    coreFetch = 1'b1;
    coreAddr  = addr;
    coreOvl   = ovl;
    expValid  = !extMemSel && (bank != NO_BANK);
    if (bank == BASE_BANK)
      expData = refBase[addr[BASE_AW-1:0]];
    else if (bank != NO_BANK)
      expData = refOvl[bank][addr[OVL_AW-1:0]];
    else
      expData = '0;
    fetchCount++;
    nextCycle();
  endtask

  // One fetch per cycle back to back
  task automatic fetchRange(input logic [CM_ADDR_W-1:0] addr, input logic [OVL_W-1:0] ovl,
                            input int n);
    for (int k = 0; k < n; k++)
      fetchWord(addr + CM_ADDR_W'(k), ovl);
    idleCycle();
  endtask

  task automatic runBoundaryPass(input logic bdry);
    logic [CM_ADDR_W-1:0] ovlBase;
    logic [OVL_W-1:0]     ovlList [4];
    ovlList   = '{4'd0, 4'd3, 4'd5, 4'd7};
    pmBdrySel = bdry;
    ovlBase   = bdry ? 14'h1000 : 14'h2000;
    bootBlock(14'h0100, 4'd0, 8'd0);            // 256 words
    bootBlock(14'h0180, 4'd0, 8'd4);            // Small block inside the big one
    fetchRange(14'h0100, 4'd0, 256);
    for (int i = 0; i < 4; i++)
      bootBlock(ovlBase + 14'h020, ovlList[i], 8'd16);
    for (int i = 0; i < 4; i++)
      fetchRange(ovlBase + 14'h020, ovlList[i], 16);
    fetchWord(ovlBase + 14'h025, 4'd8);         // Missing overlay banks
    fetchWord(ovlBase + 14'h025, 4'd15);
    fetchWord(14'h3abc, 4'd0);                  // Outside both regions
    fetchWord(14'h2020, 4'd3);                  // Overlay in 8K mode only
    fetchWord(14'h1020, 4'd3);                  // Overlay in 4K mode and base in 8K mode
    fetchWord(14'h0110, 4'd12);                 // Base ignores the overlay index
    extMemSel = 1'b1;
    fetchWord(14'h0105, 4'd0);
    extMemSel = 1'b0;
    fetchWord(14'h0105, 4'd0);
    idleCycle();
  endtask

  // Checks run on the falling edge where all outputs are settled
  assert property (@(negedge DSPCLK) $fell(rst) |->
    (!readValid && !bootBusy && !bootDone && (uut.uBootSeq.state == BOOT_IDLE)))
    else
    begin
      errCount++;
      $display("[ERROR] %0t outputs not in their reset state after reset", $time);
    end

  assert property (@(negedge DSPCLK) disable iff (rst) readValid == prevExpValid)
    else
    begin
      errCount++;
      $display("[ERROR] %0t readValid: got %0b, expected %0b", $time, readValid, prevExpValid);
    end

  assert property (@(negedge DSPCLK) disable iff (rst)
    prevExpValid |-> (readData === prevExpData))
    else
    begin
      errCount++;
      $display("[ERROR] %0t readData: got %06h, expected %06h", $time, readData, prevExpData);
    end

  assert property (@(negedge DSPCLK) disable iff (rst) bootBusy == expBusy)
    else
    begin
      errCount++;
      $display("[ERROR] %0t bootBusy: got %0b, expected %0b", $time, bootBusy, expBusy);
    end

  assert property (@(negedge DSPCLK) disable iff (rst) bootDone == expDone)
    else
    begin
      errCount++;
      $display("[ERROR] %0t bootDone: got %0b, expected %0b", $time, bootDone, expDone);
    end

  initial
  begin
    void'($urandom(32'h5f083eb8));
    rst       = 1'b1;
    pmBdrySel = 1'b1;
    extMemSel = 1'b0;
    coreFetch = 1'b0;
    coreAddr  = '0;
    coreOvl   = '0;
    bootStart = 1'b0;
    bootAddr  = '0;
    bootOvl   = '0;
    bootLen   = '0;
    byteValid = 1'b0;
    byteData  = '0;
    expValid  = 1'b0;
    expData   = '0;
    expBusy   = 1'b0;
    expDone   = 1'b0;
    repeat (3) @(posedge DSPCLK);
    #1 rst = 1'b0;
    nextCycle();                               // Reset state is checked in this cycle
    runBoundaryPass(1'b1);
    runBoundaryPass(1'b0);
    repeat (2) idleCycle();
    $display("Done: %0d boots, %0d fetches, %0d errors", bootCount, fetchCount, errCount);
    if (errCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/cmPkg.sv
hw/bootSeq.sv
hw/byteCounter.sv
hw/wordAssembler.sv
hw/cmSelect.sv
hw/codeMem.sv
hw/cmSubsys.sv
sim/cmSubsysTb.sv

// File: Makefile
TOP = cmSubsysTb

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
